// File: sim.f
+incdir+.
cache_pkg.sv
cache_fill_fsm.sv
cache_tag_array.sv
cache_data_bank.sv
cache_read_mux.sv
cache_top.sv
cache_asserts.sv
tb_cache.sv

// File: Makefile
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build tb_cache with verilator, run it and search $(LOG) for the pass line"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module tb_cache -Mdir obj_dir
	./obj_dir/Vtb_cache | tee $(LOG)
	grep -q "Testbench passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: tb_cache.sv
`timescale 1ns/10ps
`include "cache_defines.svh"

module tb_cache
	import cache_pkg::*;
();

	// requests of tests 1 to 6, each allowed a fill with a gap on every beat
	localparam int REQUESTS = 1 + 1 + `WORDS_PER_LINE + 2 + 1 + `WORDS_PER_LINE + 200;
	localparam int TIMEOUT_CYCLES = REQUESTS * (1 + `MEM_LATENCY + `WORDS_PER_LINE * 4) + 200;
	localparam int MIN_FILL = 1 + `MEM_LATENCY + `WORDS_PER_LINE; // request cycle to finished

	logic clk;
	logic rst_n;
	logic cpu_read;
	cache_addr_t cpu_addr;
	logic memory_data_valid;
	logic [WORD_BITS-1:0] memory_data;
	logic [WORD_BITS-1:0] cpu_data;
	logic cpu_hit;
	logic stall;
	logic [`ADDR_W-1:0] memory_address;
	logic memory_read;
	logic finished;

	logic gaps_on = 1'b0; // memory inserts random wait beats when set
	int cycle_count = 0;
	int errors = 0;
	int checks = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int test_errors_at_start = 0;
	string test_name;
	logic [TAG_W-1:0] shadow_tag [`CACHE_LINES]; // what the cache should hold per line
	logic [`CACHE_LINES-1:0] shadow_valid;

	cache_top dut (
		.clk(clk),
		.rst_n(rst_n),
		.cpu_read(cpu_read),
		.cpu_addr(cpu_addr),
		.memory_data_valid(memory_data_valid),
		.memory_data(memory_data),
		.cpu_data(cpu_data),
		.cpu_hit(cpu_hit),
		.stall(stall),
		.memory_address(memory_address),
		.memory_read(memory_read),
		.finished(finished)
	);

	bind cache_fill_fsm cache_asserts u_asserts (
		.clk(clk),
		.rst_n(rst_n),
		.busy(busy),
		.finished(finished),
		.memory_address(memory_address),
		.fill_wr(fill_wr),
		.state(state)
	);

	// memory image, every word depends on all address bits
	function automatic logic [WORD_BITS-1:0] ref_word(input logic [`ADDR_W-1:0] addr);
		logic [WORD_BITS-1:0] swapped;
		swapped = {addr[7:0], addr[15:8]};
		return (addr ^ 16'hc3a5) + (swapped << 3) + 16'h0101;
	endfunction

	function automatic cache_addr_t line_addr(input int tag, input int index, input int word);
		cache_addr_t a;
		a.tag = TAG_W'(tag);
		a.index = INDEX_W'(index);
		a.word = WORD_W'(word);
		a.byte_sel = 1'b0;
		return a;
	endfunction

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// memory model answers combinationally from the image
	assign memory_data = memory_read ? ref_word(memory_address) : '0;

	initial begin
		memory_data_valid = 1'b1;
		forever begin
			@(posedge clk);
			#2;
			memory_data_valid = gaps_on ? ($urandom_range(1) == 1) : 1'b1; // half the beats wait
		end
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count > TIMEOUT_CYCLES) begin
			$display("timeout after %0d cycles, a fill never completed", TIMEOUT_CYCLES);
			$display("Testbench failed");
			$finish;
		end
	end

	task automatic check_level(input string what, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("** Error at %0t: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic check_hit(input cache_addr_t a, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("** Error at %0t: read of %h gave cpu_hit %b, expected %b", $time, a, got, exp);
		end
	endtask

	task automatic check_data(input cache_addr_t a, input logic hit,
		input logic [WORD_BITS-1:0] got);
		logic [WORD_BITS-1:0] exp;
		// a read without a hit must show zero, byte_sel plays no part
		exp = hit ? ref_word({a.tag, a.index, a.word, 1'b0}) : '0;
		checks++;
		if (got !== exp) begin
			errors++;
			$display("** Error at %0t: read of %h with hit %b returned %h, expected %h",
				$time, a, hit, got, exp);
		end
	endtask

	task automatic check_mem_addr(input logic [`ADDR_W-1:0] got, input logic [`ADDR_W-1:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("** Error at %0t: memory_address is %h, expected %h", $time, got, exp);
		end
	endtask

	// compare process, mid cycle a hit carries the image word and anything else reads as zero
	always @(negedge clk) begin
		if (rst_n)
			check_data(cpu_addr, cpu_hit, cpu_data);
	end

	// follows a fill from the cycle after the miss until the cache reports finished
	task automatic wait_fill(input cache_addr_t a, output int fill_len);
		logic [`ADDR_W-1:0] base;
		int cycles;
		int beats;
		logic accepted;
		logic done;
		base = {a.tag, a.index, WORD_W'(0), 1'b0};
		cycles = 0;
		beats = 0;
		done = 1'b0;
		while (!done) begin
			@(negedge clk);
			cycles++;
			check_level("stall during fill", stall, 1'b1);
			check_level("memory_read during fill", memory_read, 1'b1);
			accepted = (cycles > `MEM_LATENCY) && memory_data_valid; // a beat in the burst
			if (accepted) begin
				check_mem_addr(memory_address, base + `ADDR_W'(2 * beats));
				beats++;
			end
			check_level("finished on the last beat", finished,
				accepted && (beats == `WORDS_PER_LINE));
			done = finished; // the fill ends when the cache says so
		end
		fill_len = cycles + 1; // the request cycle counts as well
		@(negedge clk);
		check_level("stall after finished", stall, 1'b0);
		check_level("finished after the last beat", finished, 1'b0);
		check_hit(a, cpu_hit, 1'b1); // the held request now hits
		shadow_valid[a.index] = 1'b1;
		shadow_tag[a.index] = a.tag;
	endtask

	// drives one read and returns the fill length, zero for a plain hit
	task automatic read_word(input cache_addr_t a, output int fill_len);
		logic exp_hit;
		exp_hit = shadow_valid[a.index] && (shadow_tag[a.index] == a.tag);
		fill_len = 0;
		@(posedge clk);
		#2;
		cpu_read = 1'b1;
		cpu_addr = a;
		@(negedge clk);
		check_hit(a, cpu_hit, exp_hit);
		if (cpu_hit)
			check_level("stall on a hit", stall, 1'b0);
		else
			wait_fill(a, fill_len);
	endtask

	task automatic open_test(input string name);
		test_name = name;
		test_errors_at_start = errors;
	endtask

	task automatic close_test();
		tests_run++;
		if (errors == test_errors_at_start) begin
			$display("test %0d %s: ok", tests_run, test_name);
		end else begin
			tests_failed++;
			$display("test %0d %s: %0d errors", tests_run, test_name, errors - test_errors_at_start);
		end
	endtask

	initial begin
		cache_addr_t a;
		int fill_len;
		void'($urandom(32'h5dca_a5b0));
		rst_n = 1'b0;
		cpu_read = 1'b0;
		cpu_addr = '0;
		shadow_valid = '0; // the cache comes out of reset cold
		repeat (5) @(posedge clk);
		#2;
		rst_n = 1'b1;

		open_test("reset levels and first miss");
		@(negedge clk);
		check_level("stall after reset", stall, 1'b0);
		check_level("memory_read after reset", memory_read, 1'b0);
		check_level("finished after reset", finished, 1'b0);
		read_word(line_addr(9'h012, 1, 3), fill_len);
		close_test();

		open_test("cold miss fill sequence");
		read_word(line_addr(9'h0a5, 4, 0), fill_len);
		check_level("fill at minimum length", fill_len == MIN_FILL, 1'b1);
		close_test();

		open_test("whole line hits");
		for (int w = 0; w < `WORDS_PER_LINE; w++) begin
			read_word(line_addr(9'h0a5, 4, w), fill_len);
			check_level("word hit without stall", fill_len == 0, 1'b1);
		end
		close_test();

		open_test("same index new tag");
		read_word(line_addr(9'h133, 4, 6), fill_len); // replaces the line of test 2
		read_word(line_addr(9'h0a5, 4, 2), fill_len); // old tag misses again
		check_level("old line refilled", fill_len > 0, 1'b1);
		close_test();

		open_test("fill with memory gaps");
		gaps_on = 1'b1;
		read_word(line_addr(9'h07e, 6, 5), fill_len);
		check_level("gapped fill longer than minimum", fill_len > MIN_FILL, 1'b1);
		for (int w = 0; w < `WORDS_PER_LINE; w++)
			read_word(line_addr(9'h07e, 6, w), fill_len);
		gaps_on = 1'b0;
		close_test();

		open_test("random reads against shadow");
		for (int i = 0; i < 200; i++) begin
			a.tag = TAG_W'($urandom_range(3)); // few tags so lines get reused
			a.index = INDEX_W'($urandom_range(`CACHE_LINES - 1));
			a.word = WORD_W'($urandom_range(`WORDS_PER_LINE - 1));
			a.byte_sel = $urandom_range(1) == 1;
			read_word(a, fill_len);
		end
		close_test();

		@(posedge clk);
		#2;
		cpu_read = 1'b0;
		$display("%0d tests, %0d failed, %0d checks, %0d errors",
			tests_run, tests_failed, checks, errors);
		if (errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

// File: cache_asserts.sv
`timescale 1ns/10ps
`include "cache_defines.svh"

module cache_asserts
	import cache_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic busy, // stall level seen by the cpu
	input logic finished,
	input logic [`ADDR_W-1:0] memory_address,
	input fill_wr_t fill_wr,
	input fill_state_t state
);

	// the last beat carries the tag write along with the final word
	a_finished_tag: assert property (@(posedge clk) disable iff (!rst_n)
		finished |-> fill_wr.tag_we)
		else $error("finished pulsed without a tag write");

	// the controller goes back to idle right after the last beat
	a_stall_drop: assert property (@(posedge clk) disable iff (!rst_n)
		finished |=> !busy)
		else $error("stall still high one cycle after finished");

	// and it never leaves a fill any other way
	a_stall_cause: assert property (@(posedge clk) disable iff (!rst_n)
		$fell(busy) |-> $past(finished))
		else $error("stall fell without a preceding finished");

	a_we_in_burst: assert property (@(posedge clk) disable iff (!rst_n)
		fill_wr.data_we |-> (state == FILL_BURST))
		else $error("data write outside the burst state");

	// memory is always addressed on word boundaries
	a_word_aligned: assert property (@(posedge clk) disable iff (!rst_n)
		memory_address[0] == 1'b0)
		else $error("memory address is not word aligned");

endmodule

// File: cache_top.sv
`timescale 1ns/10ps
`include "cache_defines.svh"

module cache_top
	import cache_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic cpu_read,
	input cache_addr_t cpu_addr,
	input logic memory_data_valid,
	input logic [WORD_BITS-1:0] memory_data,
	output logic [WORD_BITS-1:0] cpu_data,
	output logic cpu_hit,
	output logic stall, // busy level of the fill controller
	output logic [`ADDR_W-1:0] memory_address,
	output logic memory_read,
	output logic finished
);

	logic hit;
	logic miss_detected;
	fill_wr_t fill_wr; // fans out to the tag array and all banks
	logic [`WORDS_PER_LINE-1:0][WORD_BITS-1:0] bank_rd;

	cache_tag_array u_tag_array (
		.clk(clk),
		.rst_n(rst_n),
		.cpu_read(cpu_read),
		.cpu_addr(cpu_addr),
		.busy(stall), // masks new misses while a line is coming in
		.fill_wr(fill_wr),
		.hit(hit),
		.miss_detected(miss_detected)
	);

	// the cpu address doubles as the miss address since it is held during the stall
	cache_fill_fsm u_fill_fsm (
		.clk(clk),
		.rst_n(rst_n),
		.miss_detected(miss_detected),
		.miss_address(cpu_addr),
		.memory_data_valid(memory_data_valid),
		.memory_data(memory_data),
		.busy(stall),
		.memory_address(memory_address),
		.memory_read(memory_read),
		.finished(finished),
		.fill_wr(fill_wr)
	);

	// one bank per word position
	for (genvar w = 0; w < `WORDS_PER_LINE; w++) begin : g_bank
		cache_data_bank #(
			.WORD_POS(w)
		) u_bank (
			.clk(clk),
			.fill_wr(fill_wr),
			.rd_index(cpu_addr.index),
			.rd_data(bank_rd[w])
		);
	end

	cache_read_mux u_read_mux (
		.bank_rd(bank_rd),
		.cpu_addr(cpu_addr),
		.hit(hit),
		.cpu_data(cpu_data),
		.cpu_hit(cpu_hit)
	);

endmodule

// File: cache_read_mux.sv
`timescale 1ns/10ps
`include "cache_defines.svh"

module cache_read_mux
	import cache_pkg::*;
(
	input logic [`WORDS_PER_LINE-1:0][WORD_BITS-1:0] bank_rd, // one word per bank, same line
	input cache_addr_t cpu_addr,
	input logic hit,
	output logic [WORD_BITS-1:0] cpu_data,
	output logic cpu_hit
);

	logic [WORD_BITS-1:0] word_sel;

	// every bank already reads the addressed line, the word field picks the bank
	assign word_sel = bank_rd[cpu_addr.word];

	// without a hit the banks may hold another line or nothing at all
	// so the data bus is driven to zero and no stale word gets out
	assign cpu_data = hit ? word_sel : '0;

	assign cpu_hit = hit;

endmodule

// File: cache_data_bank.sv
`timescale 1ns/10ps
`include "cache_defines.svh"

module cache_data_bank
	import cache_pkg::*;
#(
	parameter int WORD_POS = 0 // word position inside a line held by this bank
) (
	input logic clk,
	input fill_wr_t fill_wr, // shared by all banks, each picks out its own word
	input logic [INDEX_W-1:0] rd_index, // line addressed by the cpu
	output logic [WORD_BITS-1:0] rd_data
);

	// one word of every line lives here
	logic [WORD_BITS-1:0] mem [`CACHE_LINES];
	logic bank_we;

	// only the beat carrying this bank's word position is stored
	assign bank_we = fill_wr.data_we && (fill_wr.word == WORD_W'(WORD_POS));

	always_ff @(posedge clk) begin
		if (bank_we)
			mem[fill_wr.index] <= fill_wr.data;
	end

	// asynchronous read so a hit is answered in the request cycle
	assign rd_data = mem[rd_index];

endmodule

// File: cache_tag_array.sv
`timescale 1ns/10ps
`include "cache_defines.svh"

module cache_tag_array
	import cache_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic cpu_read, // plain level, no handshake
	input cache_addr_t cpu_addr,
	input logic busy, // fill in progress
	input fill_wr_t fill_wr,
	output logic hit,
	output logic miss_detected
);

	logic [TAG_W-1:0] tags [`CACHE_LINES]; // one tag per line
	logic [`CACHE_LINES-1:0] valid; // line holds a complete fill
	logic tag_match;

	// a line only matches once its valid bit is set, so an unwritten tag is never compared on its own
	assign tag_match = valid[cpu_addr.index] && (tags[cpu_addr.index] == cpu_addr.tag);

	// hits come back in the same cycle as the read
	assign hit = cpu_read && tag_match;

	// new misses are ignored during a fill
	// the cpu keeps its request up, so it is seen again once the line is in
	assign miss_detected = cpu_read && !tag_match && !busy;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid <= '0; // cache starts cold
		end else if (fill_wr.tag_we) begin
			valid[fill_wr.index] <= 1'b1;
		end
	end

	// tags are written together with the valid bit on the last beat of a fill
	always_ff @(posedge clk) begin
		if (fill_wr.tag_we)
			tags[fill_wr.index] <= fill_wr.tag;
	end

endmodule

// File: cache_fill_fsm.sv
`timescale 1ns/10ps
`include "cache_defines.svh"

module cache_fill_fsm
	import cache_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic miss_detected, // already masked by the tag array while a fill runs
	input cache_addr_t miss_address, // the cpu holds this steady during the fill
	input logic memory_data_valid, // low during the burst holds the word count
	input logic [WORD_BITS-1:0] memory_data,
	output logic busy, // doubles as the cpu stall level
	output logic [`ADDR_W-1:0] memory_address,
	output logic memory_read,
	output logic finished, // one cycle pulse on the last accepted beat
	output fill_wr_t fill_wr
);

	// wide enough to hold MEM_LATENCY itself, the count overshoots by one on the last wait cycle
	localparam int LAT_W = $clog2(`MEM_LATENCY + 1);

	fill_state_t state;
	fill_state_t state_next;
	logic [LAT_W-1:0] lat_cnt; // cycles spent in the wait state so far
	logic [WORD_W-1:0] word_cnt; // word position of the next beat
	logic [TAG_W-1:0] fill_tag; // tag of the line being fetched
	logic [INDEX_W-1:0] fill_index; // line being fetched
	logic lat_done;
	logic beat;
	logic last_beat;

	assign lat_done = (lat_cnt == LAT_W'(`MEM_LATENCY - 1)); // last cycle of the wait
	assign beat = (state == FILL_BURST) && memory_data_valid; // a beat only counts in the burst
	assign last_beat = beat && (word_cnt == WORD_W'(`WORDS_PER_LINE - 1));

	always_comb begin
		state_next = state;
		case (state)
			FILL_IDLE: begin
				if (miss_detected)
					state_next = FILL_WAIT;
			end
			FILL_WAIT: begin
				if (lat_done)
					state_next = FILL_BURST;
			end
			FILL_BURST: begin
				if (last_beat)
					state_next = FILL_IDLE; // stall drops in the cycle after finished
			end
			default: state_next = FILL_IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= FILL_IDLE;
			lat_cnt <= '0;
			word_cnt <= '0;
		end else begin
			state <= state_next;
			// the latency count only runs in the wait state and restarts at zero otherwise
			if (state == FILL_WAIT)
				lat_cnt <= lat_cnt + 1'b1;
			else
				lat_cnt <= '0;
			if (beat)
				word_cnt <= word_cnt + 1'b1; // wraps back to zero after the last word
		end
	end

	// miss address is taken on the same edge that leaves idle
	always_ff @(posedge clk) begin
		if ((state == FILL_IDLE) && miss_detected) begin
			fill_tag <= miss_address.tag;
			fill_index <= miss_address.index;
		end
	end

	// line base plus twice the word count, the concatenation keeps bit zero a constant zero
	assign memory_address = {fill_tag, fill_index, word_cnt, 1'b0};

	assign busy = (state != FILL_IDLE);
	assign memory_read = (state == FILL_WAIT) || (state == FILL_BURST);
	assign finished = last_beat;

	always_comb begin
		fill_wr.data_we = beat; // every accepted beat lands in the bank for word_cnt
		fill_wr.tag_we = last_beat; // tag and valid go in once all words are there
		fill_wr.index = fill_index;
		fill_wr.word = word_cnt;
		fill_wr.tag = fill_tag;
		fill_wr.data = memory_data;
	end

endmodule

// File: cache_pkg.sv
`include "cache_defines.svh"

package cache_pkg;

	// field widths follow from the geometry in the defines header
	localparam int WORD_BITS = 16; // width of one cached word
	localparam int INDEX_W = $clog2(`CACHE_LINES); // picks the line
	localparam int WORD_W = $clog2(`WORDS_PER_LINE); // picks the word inside a line
	localparam int TAG_W = `ADDR_W - INDEX_W - WORD_W - 1; // whatever sits above index and word

	// byte address split the way the cache looks at it, msb first
	typedef struct packed {
		logic [TAG_W-1:0] tag;
		logic [INDEX_W-1:0] index;
		logic [WORD_W-1:0] word;
		logic byte_sel; // only whole words are read so this bit is ignored
	} cache_addr_t;

	// one write from the fill controller, fanned out to every bank and the tag array
	typedef struct packed {
		logic data_we; // one word of the line is written this cycle
		logic tag_we; // last beat, tag and valid bit are written
		logic [INDEX_W-1:0] index; // line being filled
		logic [WORD_W-1:0] word; // word position of this beat
		logic [TAG_W-1:0] tag; // tag of the missed address
		logic [WORD_BITS-1:0] data; // word straight off the memory bus
	} fill_wr_t;

	// the controller is either idle, waiting out memory latency, or taking beats
	typedef enum logic [1:0] {
		FILL_IDLE,
		FILL_WAIT,
		FILL_BURST
	} fill_state_t;

endpackage

// File: cache_defines.svh
`ifndef CACHE_DEFINES_SVH
`define CACHE_DEFINES_SVH

// number of lines in the direct-mapped cache, one tag and valid bit each
`define CACHE_LINES 8

// 16-bit words held by every line
// the fill controller lets its word counter wrap, so keep this a power of two
`define WORDS_PER_LINE 8

// width of a cpu or memory byte address
// a word spans two byte addresses, bit zero is never used for selection
`define ADDR_W 16

// cycles the fill controller sits in its wait state after a miss
// before the first memory beat can be accepted
`define MEM_LATENCY 4

`endif
